// ==== cial_cfg_pkg.sv ====
// sizes and widths for the completion-queue interrupt aggregator
// cq counts per class, index widths, depth width and class arbiter size

package cial_cfg_pkg;

  // ----------------------------------------------------------
  // cq counts and index widths
  // ----------------------------------------------------------
  localparam int NUM_DIR_CQ = 16;           // directed cqs
  localparam int NUM_LDB_CQ = 8;            // load-balanced cqs

  localparam int DIR_CQ_W = 4;              // dir cq index
  localparam int LDB_CQ_W = 3;              // ldb cq index
  localparam int CQ_W     = DIR_CQ_W;       // common cq field in the request word

  // ----------------------------------------------------------
  // depth and class arbitration
  // ----------------------------------------------------------
  // reported queue depth and the per-class threshold share one width
  localparam int DEPTH_W = 12;

  // class arbiter requests, bit 0 is ldb and bit 1 is dir
  localparam int NUM_CLASS = 2;

endpackage

// ==== cial_msg_pkg.sv ====
// interrupt request word sent out of the aggregator
// dir and ldb views of the word, the union over both, parity coverage width

package cial_msg_pkg;

  import cial_cfg_pkg::*;

  // ----------------------------------------------------------
  // parity coverage
  // ----------------------------------------------------------
  // class bit plus the full cq field, parity makes the total odd
  localparam int IRQ_PAR_W = 1 + CQ_W;

  // ----------------------------------------------------------
  // request word views
  // ----------------------------------------------------------
  // dir reading, class bit is 0
  typedef struct packed {
    logic                parity;
    logic                is_ldb;
    logic [DIR_CQ_W-1:0] cq;
  } irq_dir_view_t;

  // ldb reading, class bit is 1 and the pad above the cq stays 0
  typedef struct packed {
    logic                       parity;
    logic                       is_ldb;
    logic [CQ_W-LDB_CQ_W-1:0]   pad;
    logic [LDB_CQ_W-1:0]        cq;
  } irq_ldb_view_t;

  // one 6-bit word, decoded by its class bit
  typedef union packed {
    irq_dir_view_t dir;
    irq_ldb_view_t ldb;
  } irq_req_t;

endpackage

// ==== cq_int_state.sv ====
// per-cq interrupt state for one class of completion queues
// armed bits set by config writes, pending bits set by qualifying
// enqueue exceptions and cleared when the cq is granted

module cq_int_state
  import cial_cfg_pkg::*;
#(
  parameter int NUM_CQ = NUM_DIR_CQ
) (
    input  logic                        i_clk
  , input  logic                        i_arst_n

  // enqueue exception event
  , input  logic                        i_excep_v
  , input  logic [$clog2(NUM_CQ)-1:0]   i_excep_cq
  , input  logic [DEPTH_W-1:0]          i_excep_depth

  // configuration
  , input  logic [DEPTH_W-1:0]          i_cfg_thresh
  , input  logic                        i_cfg_arm_we
  , input  logic [NUM_CQ-1:0]           i_cfg_arm
  , input  logic [NUM_CQ-1:0]           i_cfg_int_en

  // grant from the class selection
  , input  logic                        i_grant
  , input  logic [$clog2(NUM_CQ)-1:0]   i_grant_cq

  , output logic [NUM_CQ-1:0]           o_armed
  , output logic [NUM_CQ-1:0]           o_pending
);

  logic [NUM_CQ-1:0] armed_q;
  logic [NUM_CQ-1:0] armed_d;
  logic [NUM_CQ-1:0] pending_q;
  logic [NUM_CQ-1:0] pending_d;
  logic              depth_hit;
  logic              excep_hit;

  // ----------------------------------------------------------
  // event qualification
  // ----------------------------------------------------------
  assign depth_hit = (i_excep_depth >= i_cfg_thresh);  // at or above threshold

  assign excep_hit = i_excep_v
                   & depth_hit
                   & i_cfg_int_en[i_excep_cq]
                   & armed_q[i_excep_cq];

  // ----------------------------------------------------------
  // next state
  // ----------------------------------------------------------
  always_comb begin
    armed_d   = armed_q;
    pending_d = pending_q;

    if (i_grant) begin
      pending_d[i_grant_cq] = 1'b0;  // request is on its way out
    end

    // a new event on the same cq wins over the grant clear
    if (excep_hit) begin
      armed_d[i_excep_cq]   = 1'b0;
      pending_d[i_excep_cq] = 1'b1;
    end

    // a rearm in the same cycle as the event leaves the cq armed
    if (i_cfg_arm_we) begin
      armed_d = armed_d | i_cfg_arm;
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      armed_q   <= '0;
      pending_q <= '0;
    end else begin
      armed_q   <= armed_d;
      pending_q <= pending_d;
    end
  end

  assign o_armed   = armed_q;
  assign o_pending = pending_q;

endmodule

// ==== cq_rr_arb.sv ====
// round-robin arbiter with a registered priority pointer
// combinational winner, pointer moves past the winner on update

module cq_rr_arb
  import cial_cfg_pkg::*;
#(
  parameter int NUM_REQS = NUM_DIR_CQ
) (
    input  logic                          i_clk
  , input  logic                          i_arst_n
  , input  logic [NUM_REQS-1:0]           i_reqs
  , input  logic                          i_update      // winner was taken
  , output logic                          o_winner_v
  , output logic [$clog2(NUM_REQS)-1:0]   o_winner
);

  localparam int IDX_W = $clog2(NUM_REQS);

  logic [IDX_W-1:0] ptr_q;
  logic [IDX_W-1:0] ptr_d;

  // ----------------------------------------------------------
  // winner search starting at the pointer
  // ----------------------------------------------------------
  always_comb begin
    int unsigned idx;

    o_winner_v = 1'b0;
    o_winner   = '0;
    for (int unsigned i = 0; i < NUM_REQS; i++) begin
      idx = (ptr_q + i) % NUM_REQS;  // wraps past the top request
      if (!o_winner_v && i_reqs[idx]) begin
        o_winner_v = 1'b1;
        o_winner   = idx[IDX_W-1:0];
      end
    end
  end

  // ----------------------------------------------------------
  // pointer update
  // ----------------------------------------------------------
  always_comb begin
    ptr_d = ptr_q;
    if (i_update && o_winner_v) begin
      if (o_winner == IDX_W'(NUM_REQS - 1)) begin
        ptr_d = '0;
      end else begin
        ptr_d = o_winner + 1'b1;  // next search starts one past the winner
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      ptr_q <= '0;
    end else begin
      ptr_q <= ptr_d;
    end
  end

endmodule

// ==== irq_select.sv ====
// class selection between the dir and ldb cq winners
// grant strobes per class, load strobe, request word with odd parity

module irq_select
  import cial_cfg_pkg::*, cial_msg_pkg::*;
(
    input  logic                  i_clk
  , input  logic                  i_arst_n

  // per-class winners
  , input  logic                  i_dir_v
  , input  logic [DIR_CQ_W-1:0]   i_dir_cq
  , input  logic                  i_ldb_v
  , input  logic [LDB_CQ_W-1:0]   i_ldb_cq

  , input  logic                  i_accept       // output register can take a word

  , output logic                  o_grant_dir
  , output logic                  o_grant_ldb
  , output logic                  o_load
  , output irq_req_t              o_req
);

  logic                         cls_v;
  logic [$clog2(NUM_CLASS)-1:0] cls_win;       // 1 selects dir
  logic                         cls_update;
  irq_req_t                     req_word;
  logic [IRQ_PAR_W-1:0]         par_data;

  // ----------------------------------------------------------
  // class arbiter
  // ----------------------------------------------------------
  cq_rr_arb #(
    .NUM_REQS ( NUM_CLASS )
  ) i_cls_arb (
      .i_clk      ( i_clk )
    , .i_arst_n   ( i_arst_n )
    , .i_reqs     ( {i_dir_v, i_ldb_v} )
    , .i_update   ( cls_update )
    , .o_winner_v ( cls_v )
    , .o_winner   ( cls_win )
  );

  assign cls_update  = i_accept & cls_v;  // no grant while the output is stalled
  assign o_load      = cls_update;
  assign o_grant_dir = cls_update &  cls_win[0];
  assign o_grant_ldb = cls_update & ~cls_win[0];

  // ----------------------------------------------------------
  // request word
  // ----------------------------------------------------------
  always_comb begin
    req_word = '0;
    if (cls_win[0]) begin
      req_word.dir.is_ldb = 1'b0;
      req_word.dir.cq     = i_dir_cq;
    end else begin
      req_word.ldb.is_ldb = 1'b1;
      req_word.ldb.pad    = '0;
      req_word.ldb.cq     = i_ldb_cq;
    end

    // the full cq field is covered, so the ldb pad counts as well
    par_data            = {req_word.dir.is_ldb, req_word.dir.cq};
    req_word.dir.parity = ~^par_data;  // odd
  end

  assign o_req = req_word;

endmodule

// ==== irq_out_reg.sv ====
// one-entry holding register for the interrupt request word
// valid/ready handshake toward the consumer, empty flag for idle

module irq_out_reg
  import cial_msg_pkg::*;
(
    input  logic      i_clk
  , input  logic      i_arst_n

  , input  logic      i_load      // new word from the class selection
  , input  irq_req_t  i_req
  , input  logic      i_ready

  , output logic      o_accept    // a load this cycle will be taken
  , output logic      o_valid
  , output irq_req_t  o_req
  , output logic      o_empty
);

  logic     valid_q;
  logic     take;
  irq_req_t req_q;

  // ----------------------------------------------------------
  // handshake
  // ----------------------------------------------------------
  assign take     = valid_q & i_ready;
  assign o_accept = ~valid_q | i_ready;   // empty, or emptied this edge

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      valid_q <= 1'b0;
    end else if (i_load) begin
      valid_q <= 1'b1;
    end else if (take) begin
      valid_q <= 1'b0;
    end
  end

  // payload holds still until the next load
  always_ff @(posedge i_clk) begin
    if (i_load) begin
      req_q <= i_req;
    end
  end

  assign o_valid = valid_q;
  assign o_req   = req_q;
  assign o_empty = ~valid_q;

endmodule

// ==== cq_int_top.sv ====
// completion-queue interrupt aggregator top level
// per-class cq state and round-robin arbiters, class selection,
// output holding register and the idle flag

module cq_int_top
  import cial_cfg_pkg::*, cial_msg_pkg::*;
(
    input  logic                    i_clk
  , input  logic                    i_arst_n

  // dir class
  , input  logic                    i_excep_dir_v
  , input  logic [DIR_CQ_W-1:0]     i_excep_dir_cq
  , input  logic [DEPTH_W-1:0]      i_excep_dir_depth
  , input  logic [DEPTH_W-1:0]      i_cfg_thresh_dir
  , input  logic                    i_cfg_arm_dir_we
  , input  logic [NUM_DIR_CQ-1:0]   i_cfg_arm_dir
  , input  logic [NUM_DIR_CQ-1:0]   i_cfg_int_en_dir
  , input  logic [NUM_DIR_CQ-1:0]   i_cfg_mask_dir

  // ldb class
  , input  logic                    i_excep_ldb_v
  , input  logic [LDB_CQ_W-1:0]     i_excep_ldb_cq
  , input  logic [DEPTH_W-1:0]      i_excep_ldb_depth
  , input  logic [DEPTH_W-1:0]      i_cfg_thresh_ldb
  , input  logic                    i_cfg_arm_ldb_we
  , input  logic [NUM_LDB_CQ-1:0]   i_cfg_arm_ldb
  , input  logic [NUM_LDB_CQ-1:0]   i_cfg_int_en_ldb
  , input  logic [NUM_LDB_CQ-1:0]   i_cfg_mask_ldb

  , output logic [NUM_DIR_CQ-1:0]   o_armed_dir
  , output logic [NUM_LDB_CQ-1:0]   o_armed_ldb
  , output logic [NUM_DIR_CQ-1:0]   o_irq_dir
  , output logic [NUM_LDB_CQ-1:0]   o_irq_ldb

  // request output
  , output irq_req_t                o_req
  , output logic                    o_req_valid
  , input  logic                    i_req_ready

  , output logic                    o_idle
);

  logic [NUM_DIR_CQ-1:0] arb_reqs_dir;
  logic [NUM_LDB_CQ-1:0] arb_reqs_ldb;
  logic                  winner_v_dir;
  logic                  winner_v_ldb;
  logic [DIR_CQ_W-1:0]   winner_dir;
  logic [LDB_CQ_W-1:0]   winner_ldb;
  logic                  grant_dir;
  logic                  grant_ldb;
  logic                  load;
  logic                  accept;
  logic                  out_empty;
  irq_req_t              sel_req;

  // ----------------------------------------------------------
  // per-class cq state
  // ----------------------------------------------------------
  cq_int_state #(
    .NUM_CQ ( NUM_DIR_CQ )
  ) i_state_dir (
      .i_clk         ( i_clk )
    , .i_arst_n      ( i_arst_n )
    , .i_excep_v     ( i_excep_dir_v )
    , .i_excep_cq    ( i_excep_dir_cq )
    , .i_excep_depth ( i_excep_dir_depth )
    , .i_cfg_thresh  ( i_cfg_thresh_dir )
    , .i_cfg_arm_we  ( i_cfg_arm_dir_we )
    , .i_cfg_arm     ( i_cfg_arm_dir )
    , .i_cfg_int_en  ( i_cfg_int_en_dir )
    , .i_grant       ( grant_dir )
    , .i_grant_cq    ( winner_dir )
    , .o_armed       ( o_armed_dir )
    , .o_pending     ( o_irq_dir )
  );

  cq_int_state #(
    .NUM_CQ ( NUM_LDB_CQ )
  ) i_state_ldb (
      .i_clk         ( i_clk )
    , .i_arst_n      ( i_arst_n )
    , .i_excep_v     ( i_excep_ldb_v )
    , .i_excep_cq    ( i_excep_ldb_cq )
    , .i_excep_depth ( i_excep_ldb_depth )
    , .i_cfg_thresh  ( i_cfg_thresh_ldb )
    , .i_cfg_arm_we  ( i_cfg_arm_ldb_we )
    , .i_cfg_arm     ( i_cfg_arm_ldb )
    , .i_cfg_int_en  ( i_cfg_int_en_ldb )
    , .i_grant       ( grant_ldb )
    , .i_grant_cq    ( winner_ldb )
    , .o_armed       ( o_armed_ldb )
    , .o_pending     ( o_irq_ldb )
  );

  // ----------------------------------------------------------
  // per-class cq arbiters
  // ----------------------------------------------------------
  // mask only hides a cq from arbitration, its pending bit stays
  assign arb_reqs_dir = o_irq_dir & ~i_cfg_mask_dir;
  assign arb_reqs_ldb = o_irq_ldb & ~i_cfg_mask_ldb;

  cq_rr_arb #(
    .NUM_REQS ( NUM_DIR_CQ )
  ) i_arb_dir (
      .i_clk      ( i_clk )
    , .i_arst_n   ( i_arst_n )
    , .i_reqs     ( arb_reqs_dir )
    , .i_update   ( grant_dir )
    , .o_winner_v ( winner_v_dir )
    , .o_winner   ( winner_dir )
  );

  cq_rr_arb #(
    .NUM_REQS ( NUM_LDB_CQ )
  ) i_arb_ldb (
      .i_clk      ( i_clk )
    , .i_arst_n   ( i_arst_n )
    , .i_reqs     ( arb_reqs_ldb )
    , .i_update   ( grant_ldb )
    , .o_winner_v ( winner_v_ldb )
    , .o_winner   ( winner_ldb )
  );

  // ----------------------------------------------------------
  // class selection and output register
  // ----------------------------------------------------------
  irq_select i_select (
      .i_clk       ( i_clk )
    , .i_arst_n    ( i_arst_n )
    , .i_dir_v     ( winner_v_dir )
    , .i_dir_cq    ( winner_dir )
    , .i_ldb_v     ( winner_v_ldb )
    , .i_ldb_cq    ( winner_ldb )
    , .i_accept    ( accept )
    , .o_grant_dir ( grant_dir )
    , .o_grant_ldb ( grant_ldb )
    , .o_load      ( load )
    , .o_req       ( sel_req )
  );

  irq_out_reg i_out_reg (
      .i_clk    ( i_clk )
    , .i_arst_n ( i_arst_n )
    , .i_load   ( load )
    , .i_req    ( sel_req )
    , .i_ready  ( i_req_ready )
    , .o_accept ( accept )
    , .o_valid  ( o_req_valid )
    , .o_req    ( o_req )
    , .o_empty  ( out_empty )
  );

  // idle once nothing is pending and the output word is gone
  assign o_idle = ~((|o_irq_dir) | (|o_irq_ldb)) & out_empty;

endmodule

// ==== tb_cq_int.sv ====
// testbench for the completion-queue interrupt aggregator
// stimulus table, cycle reference model, output checks and watchdog

module tb_cq_int
  import cial_cfg_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 20;
  localparam int NUM_ROWS   = 17;
  localparam int DRAIN_MAX  = 200;
  localparam int RDY_HI     = 0;
  localparam int RDY_RAND   = 1;
  localparam int RDY_LOW    = 2;

  typedef struct packed {
    logic [3:0]         test;
    logic               ldb;
    logic [3:0]         cq;
    logic [DEPTH_W-1:0] depth;
    logic [DEPTH_W-1:0] thresh;
    logic               arm;       // arm write before the event
    logic               en;
    logic               mask;
    logic               ev;
    logic               exp_pend;  // pending bit right after the event
    logic               chk_lat;   // request due two cycles after the event
    logic [1:0]         ready;
    logic [7:0]         hold;
    logic               drain;
  } row_t;

  logic clk;
  logic arst_n;
  logic excep_dir_v, excep_ldb_v;
  logic [DIR_CQ_W-1:0] excep_dir_cq;
  logic [LDB_CQ_W-1:0] excep_ldb_cq;
  logic [DEPTH_W-1:0] excep_dir_depth, excep_ldb_depth, thresh_dir, thresh_ldb;
  logic arm_dir_we, arm_ldb_we;
  logic [NUM_DIR_CQ-1:0] arm_dir, en_dir, mask_dir, armed_dir, irq_dir;
  logic [NUM_LDB_CQ-1:0] arm_ldb, en_ldb, mask_ldb, armed_ldb, irq_ldb;
  logic [5:0] req;
  logic req_valid, req_ready, idle;

  // reference model state
  logic [NUM_DIR_CQ-1:0] m_armed_dir = '0;
  logic [NUM_DIR_CQ-1:0] m_pend_dir  = '0;
  logic [NUM_LDB_CQ-1:0] m_armed_ldb = '0;
  logic [NUM_LDB_CQ-1:0] m_pend_ldb  = '0;
  int                    m_ptr_dir, m_ptr_ldb, m_ptr_cls;
  logic                  m_valid = 1'b0;
  logic [5:0]            m_word  = '0;
  logic                  stall_q = 1'b0;
  logic [5:0]            last_req;

  int    errors, checks, n_tests, n_failed, err_base, cur_test, ready_mode;
  int    seed;
  logic  chk_en;
  row_t  rows [NUM_ROWS];
  string test_name [1:6];

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  cq_int_top i_dut (
      .i_clk (clk), .i_arst_n (arst_n)
    , .i_excep_dir_v (excep_dir_v), .i_excep_dir_cq (excep_dir_cq)
    , .i_excep_dir_depth (excep_dir_depth), .i_cfg_thresh_dir (thresh_dir)
    , .i_cfg_arm_dir_we (arm_dir_we), .i_cfg_arm_dir (arm_dir)
    , .i_cfg_int_en_dir (en_dir), .i_cfg_mask_dir (mask_dir)
    , .i_excep_ldb_v (excep_ldb_v), .i_excep_ldb_cq (excep_ldb_cq)
    , .i_excep_ldb_depth (excep_ldb_depth), .i_cfg_thresh_ldb (thresh_ldb)
    , .i_cfg_arm_ldb_we (arm_ldb_we), .i_cfg_arm_ldb (arm_ldb)
    , .i_cfg_int_en_ldb (en_ldb), .i_cfg_mask_ldb (mask_ldb)
    , .o_armed_dir (armed_dir), .o_armed_ldb (armed_ldb)
    , .o_irq_dir (irq_dir), .o_irq_ldb (irq_ldb)
    , .o_req (req), .o_req_valid (req_valid), .i_req_ready (req_ready)
    , .o_idle (idle)
  );

  // ----------------------------------------------------------
  // reference model
  // ----------------------------------------------------------
  // odd parity over the class bit and the 4-bit cq field with the ldb pad at 0
  function automatic logic [5:0] make_word(input logic is_ldb, input logic [3:0] cq);
    logic [4:0] body;
    body = {is_ldb, is_ldb ? {1'b0, cq[2:0]} : cq};
    return {($countones(body) % 2 == 0), body};
  endfunction

  // first request at or after ptr with wrap around, or -1 when none
  function automatic int rr_pick(input logic [15:0] reqs, input int ptr, input int n);
    int idx;
    for (int i = 0; i < n; i++) begin
      idx = (ptr + i) % n;
      if (reqs[idx]) return idx;
    end
    return -1;
  endfunction

  task automatic model_step();
    int w_dir;
    int w_ldb;
    int cls;
    w_dir = rr_pick(m_pend_dir & ~mask_dir, m_ptr_dir, NUM_DIR_CQ);
    w_ldb = rr_pick({8'b0, m_pend_ldb & ~mask_ldb}, m_ptr_ldb, NUM_LDB_CQ);
    cls   = rr_pick({14'b0, w_dir >= 0, w_ldb >= 0}, m_ptr_cls, 2);  // 1 is dir
    if ((!m_valid || req_ready) && cls >= 0) begin
      m_ptr_cls = (cls + 1) % 2;
      m_valid   = 1'b1;
      if (cls == 1) begin
        m_word            = make_word(1'b0, w_dir[3:0]);
        m_pend_dir[w_dir] = 1'b0;
        m_ptr_dir         = (w_dir + 1) % NUM_DIR_CQ;
      end else begin
        m_word            = make_word(1'b1, w_ldb[3:0]);
        m_pend_ldb[w_ldb] = 1'b0;
        m_ptr_ldb         = (w_ldb + 1) % NUM_LDB_CQ;
      end
    end else if (m_valid && req_ready) begin
      m_valid = 1'b0;
    end
    if (excep_dir_v && excep_dir_depth >= thresh_dir && en_dir[excep_dir_cq]
        && m_armed_dir[excep_dir_cq]) begin
      m_armed_dir[excep_dir_cq] = 1'b0;
      m_pend_dir[excep_dir_cq]  = 1'b1;
    end
    if (excep_ldb_v && excep_ldb_depth >= thresh_ldb && en_ldb[excep_ldb_cq]
        && m_armed_ldb[excep_ldb_cq]) begin
      m_armed_ldb[excep_ldb_cq] = 1'b0;
      m_pend_ldb[excep_ldb_cq]  = 1'b1;
    end
    if (arm_dir_we) begin
      m_armed_dir = m_armed_dir | arm_dir;
    end
    if (arm_ldb_we) begin
      m_armed_ldb = m_armed_ldb | arm_ldb;
    end
  endtask

  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      m_armed_dir = '0;
      m_armed_ldb = '0;
      m_pend_dir  = '0;
      m_pend_ldb  = '0;
      m_ptr_dir   = 0;
      m_ptr_ldb   = 0;
      m_ptr_cls   = 0;
      m_valid     = 1'b0;
      stall_q     = 1'b0;
    end else begin
      stall_q  = m_valid && !req_ready;  // word must hold across this edge
      last_req = m_word;                 // word on the output before the edge
      model_step();
    end
  end

  // ----------------------------------------------------------
  // checks
  // ----------------------------------------------------------
  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("[ERROR] %0t ns %s expected 0x%0h actual 0x%0h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic compare_model();
    check_val("o_req_valid", m_valid, req_valid);
    check_val("o_idle", !(|m_pend_dir) && !(|m_pend_ldb) && !m_valid, idle);
    check_val("o_irq_dir", m_pend_dir, irq_dir);
    check_val("o_irq_ldb", m_pend_ldb, irq_ldb);
    check_val("o_armed_dir", m_armed_dir, armed_dir);
    check_val("o_armed_ldb", m_armed_ldb, armed_ldb);
    if (m_valid) begin
      check_val("o_req", m_word, req);
    end
    if (req_valid && req[4]) begin
      check_val("o_req ldb pad", 0, req[3]);
    end
    if (stall_q) begin
      check_val("o_req while stalled", last_req, req);
    end
  endtask

  always @(negedge clk) begin
    if (chk_en) begin
      compare_model();
    end
  end

  // ----------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------
  task automatic tick();
    int rnd;
    @(negedge clk);
    case (ready_mode)
      RDY_RAND: begin
        rnd       = $random(seed);
        req_ready = rnd[4];
      end
      RDY_LOW:  req_ready = 1'b0;
      default:  req_ready = 1'b1;
    endcase
  endtask

  task automatic apply_row(input row_t r);
    int n;
    tick();
    ready_mode = r.ready;
    if (r.ldb) begin
      thresh_ldb          = r.thresh;
      en_ldb[r.cq[2:0]]   = r.en;
      mask_ldb[r.cq[2:0]] = r.mask;
    end else begin
      thresh_dir    = r.thresh;
      en_dir[r.cq]  = r.en;
      mask_dir[r.cq] = r.mask;
    end
    if (r.arm) begin
      arm_ldb_we = r.ldb;
      arm_dir_we = !r.ldb;
      arm_ldb    = r.ldb ? (8'd1 << r.cq[2:0]) : '0;
      arm_dir    = r.ldb ? '0 : (16'd1 << r.cq);
      tick();
      arm_dir_we = 1'b0;
      arm_ldb_we = 1'b0;
    end
    if (r.ev) begin
      excep_ldb_v     = r.ldb;
      excep_dir_v     = !r.ldb;
      excep_ldb_cq    = r.cq[2:0];
      excep_dir_cq    = r.cq;
      excep_ldb_depth = r.depth;
      excep_dir_depth = r.depth;
      tick();
      excep_dir_v = 1'b0;
      excep_ldb_v = 1'b0;
      if (r.ldb) begin
        check_val($sformatf("o_irq_ldb[%0d]", r.cq), r.exp_pend, irq_ldb[r.cq[2:0]]);
      end else begin
        check_val($sformatf("o_irq_dir[%0d]", r.cq), r.exp_pend, irq_dir[r.cq]);
      end
      if (r.chk_lat) begin
        tick();
        check_val("o_req_valid", 1, req_valid);
        check_val("o_req", make_word(r.ldb, r.cq), req);
      end
    end
    repeat (r.hold) tick();
    if (r.drain) begin
      n = 0;
      while (!idle && n < DRAIN_MAX) begin
        tick();
        n++;
      end
      checks++;
      assert (idle) else begin
        $display("drain timed out, o_idle still low after %0d cycles", DRAIN_MAX);
        errors++;
      end
    end
  endtask

  task automatic load_table();
    // test, ldb, cq, depth, thresh, arm, en, mask, ev, exp_pend, chk_lat, ready, hold, drain
    rows[0]  = '{2, 0,  5, 100, 64, 1, 1, 0, 1, 1, 1, RDY_HI,   0, 1};
    rows[1]  = '{3, 0,  3,  10, 64, 1, 1, 0, 1, 0, 0, RDY_HI,   2, 0};  // below threshold
    rows[2]  = '{3, 0,  7, 200, 64, 1, 0, 0, 1, 0, 0, RDY_HI,   2, 0};  // disabled
    rows[3]  = '{3, 0,  9, 200, 64, 0, 1, 0, 1, 0, 0, RDY_HI,   2, 0};  // never armed
    rows[4]  = '{3, 0,  3,  64, 64, 0, 1, 0, 1, 1, 1, RDY_HI,   0, 1};
    rows[5]  = '{3, 0,  3, 300, 64, 0, 1, 0, 1, 0, 0, RDY_HI,   2, 1};  // no rearm
    rows[6]  = '{4, 1,  2,  50, 20, 1, 1, 1, 1, 1, 0, RDY_HI,   6, 0};
    rows[7]  = '{4, 1,  2,   0, 20, 0, 1, 0, 0, 0, 0, RDY_HI,   0, 1};  // unmask
    rows[8]  = '{5, 0,  1, 500, 64, 1, 1, 0, 1, 1, 0, RDY_LOW,  0, 0};
    rows[9]  = '{5, 0, 12, 480, 64, 1, 1, 0, 1, 1, 0, RDY_LOW,  0, 0};
    rows[10] = '{5, 1,  0,  90, 20, 1, 1, 0, 1, 1, 0, RDY_LOW,  0, 0};
    rows[11] = '{5, 1,  5,  21, 20, 1, 1, 0, 1, 1, 0, RDY_LOW,  0, 0};
    rows[12] = '{5, 0, 14, 900, 64, 1, 1, 0, 1, 1, 0, RDY_RAND, 0, 0};
    rows[13] = '{5, 1,  7,  20, 20, 1, 1, 0, 1, 1, 0, RDY_RAND, 0, 0};
    rows[14] = '{5, 0,  1,  65, 64, 1, 1, 0, 1, 1, 0, RDY_RAND, 1, 0};
    rows[15] = '{6, 1,  5, 300, 20, 1, 1, 0, 1, 1, 0, RDY_RAND, 0, 1};
    rows[16] = '{6, 1,  3,  40, 20, 1, 1, 0, 1, 1, 1, RDY_HI,   0, 1};
    test_name[1] = "reset state";
    test_name[2] = "dir event to request";
    test_name[3] = "ignored events";
    test_name[4] = "masked pending cq";
    test_name[5] = "round robin under stalls";
    test_name[6] = "drain and ldb word";
  endtask

  task automatic report_test(input int t);
    int errs;
    errs = errors - err_base;
    n_tests++;
    if (errs != 0) begin
      n_failed++;
    end
    $display("test %0d %s: %s, %0d errors", t, test_name[t], (errs == 0) ? "ok" : "bad", errs);
    err_base = errors;
  endtask

  // ----------------------------------------------------------
  // main sequence and watchdog
  // ----------------------------------------------------------
  initial begin
    seed = 32'h7edc88c3;
    {excep_dir_v, excep_ldb_v, arm_dir_we, arm_ldb_we} = '0;
    {excep_dir_cq, excep_ldb_cq, excep_dir_depth, excep_ldb_depth} = '0;
    {thresh_dir, thresh_ldb, arm_dir, arm_ldb} = '0;
    {en_dir, en_ldb, mask_dir, mask_ldb} = '0;
    req_ready  = 1'b1;
    ready_mode = RDY_HI;
    chk_en     = 1'b0;
    {errors, checks, n_tests, n_failed, err_base} = '0;
    load_table();
    arst_n = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    arst_n <= 1'b1;
    chk_en <= 1'b1;
    tick();
    check_val("o_req_valid", 0, req_valid);
    check_val("o_idle", 1, idle);
    check_val("o_armed_dir", 0, armed_dir);
    check_val("o_armed_ldb", 0, armed_ldb);
    check_val("o_irq_dir", 0, irq_dir);
    check_val("o_irq_ldb", 0, irq_ldb);
    report_test(1);
    cur_test = rows[0].test;
    for (int i = 0; i < NUM_ROWS; i++) begin
      if (rows[i].test != cur_test) begin
        report_test(cur_test);
        cur_test = rows[i].test;
      end
      apply_row(rows[i]);
    end
    report_test(cur_test);
    $display("%0d tests, %0d failed, %0d checks, %0d errors", n_tests, n_failed, checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    repeat (NUM_ROWS * 40) @(posedge clk);
    $display("watchdog expired after %0d cycles, run stopped", NUM_ROWS * 40);
    $display("TB FAILED");
    $finish;
  end

endmodule

// ==== sim.f ====
cial_cfg_pkg.sv
cial_msg_pkg.sv
cq_int_state.sv
cq_rr_arb.sv
irq_select.sv
irq_out_reg.sv
cq_int_top.sv
tb_cq_int.sv

// ==== Bender.yml ====
package:
  name: cq_int_agg

sources:
  # packages first, then the design bottom up
  - cial_cfg_pkg.sv
  - cial_msg_pkg.sv
  - cq_int_state.sv
  - cq_rr_arb.sv
  - irq_select.sv
  - irq_out_reg.sv
  - cq_int_top.sv

  # testbench, top module tb_cq_int
  - target: test
    files:
      - tb_cq_int.sv
